// ==== hw/divsqrt_pkg.sv ====
// FP32 divide / square-root unit
// shared widths, FP32 field types, flag encodings, op and state types
`default_nettype none

package divsqrt_pkg;

  // --------------------
  // format
  localparam int FP_WIDTH  = 32;
  localparam int EXP_WIDTH = 8;
  localparam int MAN_WIDTH = 23;
  localparam int EXP_BIAS  = 127;

  typedef logic [FP_WIDTH-1:0]  fp_word_t;  // raw FP32 word
  typedef logic [EXP_WIDTH-1:0] exp_t;      // biased exponent field
  typedef logic [MAN_WIDTH:0]   sig_t;      // significand incl. hidden bit

  // --------------------
  // exception flags, {nv, dz, of, uf, nx}
  typedef logic [4:0] status_t;

  localparam status_t FLAG_NV = 5'b10000;  // invalid operation
  localparam status_t FLAG_DZ = 5'b01000;  // divide by zero
  localparam status_t FLAG_OF = 5'b00100;  // overflow
  localparam status_t FLAG_UF = 5'b00010;  // underflow
  localparam status_t FLAG_NX = 5'b00001;  // inexact

  // --------------------
  // operations and control states
  typedef enum logic {
    DIV  = 1'b0,
    SQRT = 1'b1
  } op_e;

  typedef enum logic [1:0] {
    IDLE = 2'd0,  // waiting for work
    BUSY = 2'd1,  // recurrence running
    HOLD = 2'd2   // result parked, downstream stalled
  } ctrl_state_e;

  // quiet NaN returned for every invalid or NaN case
  localparam fp_word_t CANON_NAN = 32'h7FC00000;

endpackage

`default_nettype wire

// ==== hw/pipe_stage.sv ====
// pipeline register stage with valid/ready flow control
// accepts when empty or when its content leaves in the same cycle,
// synchronous flush drops the held item
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
  parameter int WIDTH = 8
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             flush_i,
  // upstream side
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [WIDTH-1:0] data_i,
  // downstream side
  output logic             valid_o,
  input  logic             ready_i,
  output logic [WIDTH-1:0] data_o
);

  logic             valid_q;
  logic [WIDTH-1:0] data_q;

  // stage can take new data if downstream pops us or we only hold a bubble
  assign ready_o = ready_i | ~valid_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;  // work in flight is dropped
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // payload only moves on an accepted item
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

`default_nettype wire

// ==== hw/divsqrt_special.sv ====
// special-case check for FP32 divide and square root
// classifies both operands and produces the IEEE result and flags
// for NaN, infinity, zero and negative square-root inputs
`timescale 1ns/1ps
`default_nettype none

module divsqrt_special (
  input  divsqrt_pkg::op_e      op_i,
  input  divsqrt_pkg::fp_word_t operand_a_i,
  input  divsqrt_pkg::fp_word_t operand_b_i,
  output logic                  is_special_o,
  output divsqrt_pkg::fp_word_t result_o,
  output divsqrt_pkg::status_t  status_o
);

  localparam int FW = divsqrt_pkg::FP_WIDTH;
  localparam int EW = divsqrt_pkg::EXP_WIDTH;
  localparam int MW = divsqrt_pkg::MAN_WIDTH;

  divsqrt_pkg::exp_t     exp_a, exp_b;
  logic                  sign_a, sign_b, sign_res;
  logic                  nan_a, nan_b, snan_a, snan_b;
  logic                  inf_a, inf_b, zero_a, zero_b;
  divsqrt_pkg::fp_word_t inf_word, zero_word;

  // --------------------
  // operand classes
  assign sign_a = operand_a_i[FW-1];
  assign sign_b = operand_b_i[FW-1];
  assign exp_a  = operand_a_i[FW-2 -: EW];
  assign exp_b  = operand_b_i[FW-2 -: EW];

  assign nan_a  = (&exp_a) & (|operand_a_i[MW-1:0]);
  assign nan_b  = (&exp_b) & (|operand_b_i[MW-1:0]);
  assign snan_a = nan_a & ~operand_a_i[MW-1];  // quiet bit clear
  assign snan_b = nan_b & ~operand_b_i[MW-1];
  assign inf_a  = (&exp_a) & ~(|operand_a_i[MW-1:0]);
  assign inf_b  = (&exp_b) & ~(|operand_b_i[MW-1:0]);
  assign zero_a = ~(|exp_a);  // subnormals read as zero
  assign zero_b = ~(|exp_b);

  // sqrt only sees operand a
  assign sign_res  = sign_a ^ ((op_i == divsqrt_pkg::DIV) & sign_b);
  assign inf_word  = {sign_res, {EW{1'b1}}, {MW{1'b0}}};
  assign zero_word = {sign_res, {(FW-1){1'b0}}};

  // --------------------
  // result select
  always_comb begin
    is_special_o = 1'b1;
    result_o     = divsqrt_pkg::CANON_NAN;
    status_o     = '0;
    if (op_i == divsqrt_pkg::DIV) begin
      if (nan_a || nan_b) begin
        status_o = (snan_a || snan_b) ? divsqrt_pkg::FLAG_NV : '0;
      end else if ((zero_a && zero_b) || (inf_a && inf_b)) begin
        status_o = divsqrt_pkg::FLAG_NV;  // 0/0, inf/inf
      end else if (inf_a) begin
        result_o = inf_word;
      end else if (zero_b) begin
        result_o = inf_word;              // finite / 0
        status_o = divsqrt_pkg::FLAG_DZ;
      end else if (inf_b || zero_a) begin
        result_o = zero_word;
      end else begin
        is_special_o = 1'b0;              // both normal
      end
    end else begin
      if (nan_a) begin
        status_o = snan_a ? divsqrt_pkg::FLAG_NV : '0;
      end else if (sign_a && !zero_a) begin
        status_o = divsqrt_pkg::FLAG_NV;  // root of a negative number
      end else if (zero_a) begin
        result_o = zero_word;             // sqrt(+-0) = +-0
      end else if (inf_a) begin
        result_o = inf_word;
      end else begin
        is_special_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/divsqrt_iter.sv ====
// radix-2 restoring divide / square-root recurrence for normal operands
// one result bit per cycle over 24 steps, then a pack cycle that
// truncates, checks the exponent range and raises the flags
// done pulses 25 cycles after start
`timescale 1ns/1ps
`default_nettype none

module divsqrt_iter (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  flush_i,
  input  logic                  start_i,
  input  divsqrt_pkg::op_e      op_i,
  input  divsqrt_pkg::fp_word_t operand_a_i,
  input  divsqrt_pkg::fp_word_t operand_b_i,
  output logic                  done_o,
  output divsqrt_pkg::fp_word_t result_o,
  output divsqrt_pkg::status_t  status_o
);

  localparam int FW      = divsqrt_pkg::FP_WIDTH;
  localparam int EW      = divsqrt_pkg::EXP_WIDTH;
  localparam int MW      = divsqrt_pkg::MAN_WIDTH;
  localparam int STEPS   = MW + 1;         // result bits incl. hidden bit
  localparam int RADW    = 2 * STEPS;      // sqrt radicand, two bits per step
  localparam int REMW    = MW + 2;         // partial remainder
  localparam int EXP_MAX = (1 << EW) - 2;  // largest finite biased exponent

  // --------------------
  // setup from the operands on start
  divsqrt_pkg::exp_t  exp_a, exp_b;
  divsqrt_pkg::sig_t  sig_a, sig_b;
  logic               a_lt_b;            // quotient below 1, align by one
  logic               odd_exp;           // sqrt exponent odd, double significand
  logic [EW+1:0]      unb_a, half_a, exp_init;
  logic [REMW-1:0]    rem_init;
  logic [RADW-1:0]    rad_init;

  assign exp_a  = operand_a_i[FW-2 -: EW];
  assign exp_b  = operand_b_i[FW-2 -: EW];
  assign sig_a  = {1'b1, operand_a_i[MW-1:0]};
  assign sig_b  = {1'b1, operand_b_i[MW-1:0]};
  assign a_lt_b = sig_a < sig_b;

  assign unb_a   = {2'b00, exp_a} - (EW+2)'(divsqrt_pkg::EXP_BIAS);
  assign odd_exp = unb_a[0];
  assign half_a  = unb_a - {{(EW+1){1'b0}}, odd_exp};

  always_comb begin
    if (op_i == divsqrt_pkg::DIV) begin
      exp_init = {2'b00, exp_a} - {2'b00, exp_b} + (EW+2)'(divsqrt_pkg::EXP_BIAS)
                 - {{(EW+1){1'b0}}, a_lt_b};
      rem_init = a_lt_b ? {sig_a, 1'b0} : {1'b0, sig_a};  // dividend in [b, 2b)
    end else begin
      exp_init = {half_a[EW+1], half_a[EW+1:1]} + (EW+2)'(divsqrt_pkg::EXP_BIAS);
      rem_init = '0;
    end
    rad_init = {(odd_exp ? {sig_a, 1'b0} : {1'b0, sig_a}), {MW{1'b0}}};
  end

  // --------------------
  // recurrence state
  logic                       active_q, done_q;
  logic [$clog2(STEPS+1)-1:0] cnt_q;        // steps completed
  divsqrt_pkg::op_e           op_q;
  logic                       sign_q;
  logic [EW+1:0]              exp_q;        // two's complement, may leave range
  logic [REMW-1:0]            rem_q;
  divsqrt_pkg::sig_t          quo_q, dvs_q; // quotient/root, divisor
  logic [RADW-1:0]            rad_q;
  logic                       last_step;

  // first step runs straight off the setup values
  divsqrt_pkg::op_e  cur_op;
  logic [REMW-1:0]   cur_rem, rem_nxt;
  divsqrt_pkg::sig_t cur_quo, cur_dvs;
  logic [RADW-1:0]   cur_rad;
  logic [REMW+1:0]   rem_cat, trial, rem_sub;
  logic              take;                  // trial subtraction fits

  assign cur_op  = start_i ? op_i     : op_q;
  assign cur_rem = start_i ? rem_init : rem_q;
  assign cur_quo = start_i ? '0       : quo_q;
  assign cur_dvs = start_i ? sig_b    : dvs_q;
  assign cur_rad = start_i ? rad_init : rad_q;

  always_comb begin
    if (cur_op == divsqrt_pkg::DIV) begin
      rem_cat = {2'b00, cur_rem};
      trial   = {3'b000, cur_dvs};
    end else begin
      rem_cat = {cur_rem, cur_rad[RADW-1 -: 2]};  // bring down two bits
      trial   = {1'b0, cur_quo, 2'b01};           // 4*root + 1
    end
    take    = rem_cat >= trial;
    rem_sub = take ? rem_cat - trial : rem_cat;
    if (cur_op == divsqrt_pkg::DIV) rem_nxt = {rem_sub[MW:0], 1'b0};
    else                            rem_nxt = rem_sub[REMW-1:0];
  end

  assign last_step = active_q && (cnt_q == STEPS);  // pack cycle

  // control, cleared by reset and flush
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      active_q <= 1'b0;
      done_q   <= 1'b0;
      cnt_q    <= '0;
    end else begin
      done_q <= last_step;  // single-cycle pulse
      if (start_i) begin
        active_q <= 1'b1;
        cnt_q    <= 1;
      end else if (last_step) begin
        active_q <= 1'b0;
      end else if (active_q) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // datapath
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      op_q   <= op_i;
      sign_q <= (op_i == divsqrt_pkg::DIV) & (operand_a_i[FW-1] ^ operand_b_i[FW-1]);
      exp_q  <= exp_init;
      dvs_q  <= sig_b;
    end
    if (start_i || (active_q && !last_step)) begin
      rem_q <= rem_nxt;
      quo_q <= {cur_quo[MW-1:0], take};
      rad_q <= cur_rad << 2;
    end
  end

  // --------------------
  // pack, truncate toward zero
  always_ff @(posedge clk_i) begin
    if (last_step) begin
      if ($signed(exp_q) > EXP_MAX) begin
        result_o <= {sign_q, EW'(EXP_MAX), {MW{1'b1}}};  // largest finite
        status_o <= divsqrt_pkg::FLAG_OF | divsqrt_pkg::FLAG_NX;
      end else if ($signed(exp_q) < 1) begin
        result_o <= {sign_q, {(FW-1){1'b0}}};            // flush to zero
        status_o <= divsqrt_pkg::FLAG_UF | divsqrt_pkg::FLAG_NX;
      end else begin
        result_o <= {sign_q, exp_q[EW-1:0], quo_q[MW-1:0]};
        status_o <= (|rem_q) ? divsqrt_pkg::FLAG_NX : '0;  // bits lost
      end
    end
  end

  assign done_o = done_q;

endmodule

`default_nettype wire

// ==== hw/divsqrt_ctrl.sv ====
// control FSM of the divide / square-root unit
// IDLE takes work from the input stage, BUSY waits on the recurrence,
// HOLD parks a finished result while downstream is stalled
// also keeps the tag of the running operation and selects the output
`timescale 1ns/1ps
`default_nettype none

module divsqrt_ctrl #(
  parameter int TAG_WIDTH = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  flush_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  logic [TAG_WIDTH-1:0]  tag_i,
  input  logic                  is_special_i,
  input  divsqrt_pkg::fp_word_t special_result_i,
  input  divsqrt_pkg::status_t  special_status_i,
  output logic                  start_o,
  input  logic                  done_i,
  input  divsqrt_pkg::fp_word_t iter_result_i,
  input  divsqrt_pkg::status_t  iter_status_i,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output divsqrt_pkg::fp_word_t result_o,
  output divsqrt_pkg::status_t  status_o,
  output logic [TAG_WIDTH-1:0]  tag_o,
  output logic                  busy_o
);

  divsqrt_pkg::ctrl_state_e state_q, state_d;
  logic                     take_op;      // op leaves the input stage
  logic                     hold_load;    // park the offered result
  logic [TAG_WIDTH-1:0]     tag_q;
  divsqrt_pkg::fp_word_t    live_result, held_result_q;
  divsqrt_pkg::status_t     live_status, held_status_q;

  assign in_ready_o = (state_q == divsqrt_pkg::IDLE);  // stalls input outside IDLE
  assign take_op    = in_ready_o & in_valid_i & ~flush_i;
  assign start_o    = take_op & ~is_special_i;         // only normal ops iterate

  // --------------------
  // next state
  always_comb begin
    state_d     = state_q;
    out_valid_o = 1'b0;
    hold_load   = 1'b0;
    unique case (state_q)
      divsqrt_pkg::IDLE: begin
        if (take_op && is_special_i) begin
          out_valid_o = 1'b1;  // special result completes right away
          if (!out_ready_i) begin
            hold_load = 1'b1;
            state_d   = divsqrt_pkg::HOLD;
          end
        end else if (take_op) begin
          state_d = divsqrt_pkg::BUSY;
        end
      end
      divsqrt_pkg::BUSY: begin
        if (done_i) begin
          out_valid_o = 1'b1;
          if (out_ready_i) state_d = divsqrt_pkg::IDLE;
          else begin
            hold_load = 1'b1;
            state_d   = divsqrt_pkg::HOLD;
          end
        end
      end
      divsqrt_pkg::HOLD: begin
        out_valid_o = 1'b1;  // keep offering the parked result
        if (out_ready_i) state_d = divsqrt_pkg::IDLE;
      end
      default: state_d = divsqrt_pkg::IDLE;
    endcase
    // flush drops any result on offer
    if (flush_i) begin
      out_valid_o = 1'b0;
      hold_load   = 1'b0;
      state_d     = divsqrt_pkg::IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) state_q <= divsqrt_pkg::IDLE;
    else       state_q <= state_d;
  end

  // --------------------
  // tag and hold register
  always_ff @(posedge clk_i) begin
    if (take_op) tag_q <= tag_i;
    if (hold_load) begin
      held_result_q <= live_result;
      held_status_q <= live_status;
    end
  end

  // special result only ever offered from IDLE
  assign live_result = (state_q == divsqrt_pkg::IDLE) ? special_result_i : iter_result_i;
  assign live_status = (state_q == divsqrt_pkg::IDLE) ? special_status_i : iter_status_i;

  assign result_o = (state_q == divsqrt_pkg::HOLD) ? held_result_q : live_result;
  assign status_o = (state_q == divsqrt_pkg::HOLD) ? held_status_q : live_status;
  assign tag_o    = (state_q == divsqrt_pkg::IDLE) ? tag_i : tag_q;  // tag_q not loaded yet
  assign busy_o   = (state_q != divsqrt_pkg::IDLE);

endmodule

`default_nettype wire

// ==== hw/divsqrt_top.sv ====
// FP32 divide / square-root unit, top level
// input register stage, special-case check, restoring recurrence,
// control FSM and output register stage, with valid/ready on both sides
`timescale 1ns/1ps
`default_nettype none

module divsqrt_top #(
  parameter int TAG_WIDTH = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  divsqrt_pkg::fp_word_t operand_a_i,
  input  divsqrt_pkg::fp_word_t operand_b_i,
  input  divsqrt_pkg::op_e      op_i,
  input  logic [TAG_WIDTH-1:0]  tag_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  logic                  flush_i,
  output divsqrt_pkg::fp_word_t result_o,
  output divsqrt_pkg::status_t  status_o,
  output logic [TAG_WIDTH-1:0]  tag_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic                  busy_o
);

  localparam int FW    = divsqrt_pkg::FP_WIDTH;
  localparam int SW    = $bits(divsqrt_pkg::status_t);
  localparam int IN_W  = 1 + 2 * FW + TAG_WIDTH;  // {op, a, b, tag}
  localparam int OUT_W = FW + SW + TAG_WIDTH;     // {result, status, tag}

  // --------------------
  // input stage
  logic [IN_W-1:0]       in_data;
  logic                  in_valid_q, in_ready_q;
  divsqrt_pkg::op_e      op_q;
  divsqrt_pkg::fp_word_t opa_q, opb_q;
  logic [TAG_WIDTH-1:0]  tag_q;

  pipe_stage #(.WIDTH(IN_W)) u_in_stage (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .flush_i (flush_i),
    .valid_i (in_valid_i),
    .ready_o (in_ready_o),
    .data_i  ({op_i, operand_a_i, operand_b_i, tag_i}),
    .valid_o (in_valid_q),
    .ready_i (in_ready_q),
    .data_o  (in_data)
  );

  assign op_q  = divsqrt_pkg::op_e'(in_data[IN_W-1]);
  assign opa_q = in_data[IN_W-2 -: FW];
  assign opb_q = in_data[TAG_WIDTH +: FW];
  assign tag_q = in_data[TAG_WIDTH-1:0];

  // --------------------
  // datapath
  logic                  is_special, start, done;
  divsqrt_pkg::fp_word_t spec_result, iter_result;
  divsqrt_pkg::status_t  spec_status, iter_status;

  divsqrt_special u_special (
    .op_i         (op_q),
    .operand_a_i  (opa_q),
    .operand_b_i  (opb_q),
    .is_special_o (is_special),
    .result_o     (spec_result),
    .status_o     (spec_status)
  );

  divsqrt_iter u_iter (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .start_i     (start),
    .op_i        (op_q),
    .operand_a_i (opa_q),
    .operand_b_i (opb_q),
    .done_o      (done),
    .result_o    (iter_result),
    .status_o    (iter_status)
  );

  // --------------------
  // control and output stage
  logic                  res_valid, res_ready, ctrl_busy;
  divsqrt_pkg::fp_word_t res_result;
  divsqrt_pkg::status_t  res_status;
  logic [TAG_WIDTH-1:0]  res_tag;
  logic [OUT_W-1:0]      out_data;

  divsqrt_ctrl #(.TAG_WIDTH(TAG_WIDTH)) u_ctrl (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .flush_i          (flush_i),
    .in_valid_i       (in_valid_q),
    .in_ready_o       (in_ready_q),
    .tag_i            (tag_q),
    .is_special_i     (is_special),
    .special_result_i (spec_result),
    .special_status_i (spec_status),
    .start_o          (start),
    .done_i           (done),
    .iter_result_i    (iter_result),
    .iter_status_i    (iter_status),
    .out_valid_o      (res_valid),
    .out_ready_i      (res_ready),
    .result_o         (res_result),
    .status_o         (res_status),
    .tag_o            (res_tag),
    .busy_o           (ctrl_busy)
  );

  pipe_stage #(.WIDTH(OUT_W)) u_out_stage (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .flush_i (flush_i),
    .valid_i (res_valid),
    .ready_o (res_ready),
    .data_i  ({res_result, res_status, res_tag}),
    .valid_o (out_valid_o),
    .ready_i (out_ready_i),
    .data_o  (out_data)
  );

  assign {result_o, status_o, tag_o} = out_data;
  assign busy_o = in_valid_q | ctrl_busy | out_valid_o;  // anything in flight

endmodule

`default_nettype wire

// ==== dv/divsqrt_monitor.sv ====
// checker for the FP32 divide / square-root unit
// queues the expected result of every accepted operation and compares
// each delivered result in order, also watches busy, output stability
// while stalled, the idle state after reset and the effect of a flush
`timescale 1ns/1ps
`default_nettype none

module divsqrt_monitor #(
  parameter int TAG_WIDTH = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  in_valid_i,
  input  logic                  in_ready_i,
  input  logic [TAG_WIDTH-1:0]  in_tag_i,
  input  logic                  flush_i,
  input  logic                  out_valid_i,
  input  logic                  out_ready_i,
  input  divsqrt_pkg::fp_word_t out_result_i,
  input  divsqrt_pkg::status_t  out_status_i,
  input  logic [TAG_WIDTH-1:0]  out_tag_i,
  input  logic                  busy_i,
  // expected values for the operation on the input this cycle
  input  logic                  exp_valid_i,
  input  int                    exp_idx_i,
  input  divsqrt_pkg::fp_word_t exp_result_i,
  input  divsqrt_pkg::status_t  exp_status_i,
  output int                    pass_count_o,
  output int                    err_count_o,
  output int                    pending_o
);

  localparam int OUT_W = divsqrt_pkg::FP_WIDTH + $bits(divsqrt_pkg::status_t) + TAG_WIDTH;

  int                    q_idx [$];
  divsqrt_pkg::fp_word_t q_res [$];
  divsqrt_pkg::status_t  q_st [$];
  logic [TAG_WIDTH-1:0]  q_tag [$];

  int                    idx, last_idx;
  divsqrt_pkg::fp_word_t e_res;
  divsqrt_pkg::status_t  e_st;
  logic [TAG_WIDTH-1:0]  e_tag;
  logic                  flush_q, stall_q, reset_q;
  logic [OUT_W-1:0]      stall_data;  // {result, status, tag} seen while stalled

  always @(posedge clk_i) begin
    if (rst_i) begin
      q_idx.delete();
      q_res.delete();
      q_st.delete();
      q_tag.delete();
      pass_count_o = 0;
      err_count_o  = 0;
      flush_q      = 1'b0;
      stall_q      = 1'b0;
      reset_q      = 1'b1;
      last_idx     = 0;
    end else begin
      // --------------------
      // idle state on the first edge out of reset
      if (reset_q) begin
        if (!in_ready_i || out_valid_i || busy_i) begin
          err_count_o++;
          $display("FAIL %0d ns: after reset ready %b valid %b busy %b", $time, in_ready_i,
                   out_valid_i, busy_i);
        end else begin
          pass_count_o++;
          $display("PASS reset: input ready, no output, not busy");
        end
        reset_q = 1'b0;
      end
      // busy must cover every op from acceptance to delivery
      if (q_idx.size() > 0 && !busy_i) begin
        err_count_o++;
        $display("FAIL %0d ns: busy low with %0d results outstanding", $time, q_idx.size());
      end
      // a stalled result stays put
      if (stall_q && (!out_valid_i ||
                      stall_data != {out_result_i, out_status_i, out_tag_i})) begin
        err_count_o++;
        $display("FAIL %0d ns: output changed while stalled", $time);
      end
      if (flush_q) begin
        if (busy_i) begin
          err_count_o++;
          $display("FAIL %0d ns: test %0d busy still high after flush", $time, last_idx);
        end else begin
          pass_count_o++;
          $display("PASS test %0d: flush dropped the operation", last_idx);
        end
      end
      // --------------------
      // delivered result against the head of the queue
      if (out_valid_i && out_ready_i) begin
        if (q_idx.size() == 0) begin
          err_count_o++;
          $display("unexpected result %h with tag %0d, nothing outstanding", out_result_i,
                   out_tag_i);
        end else begin
          idx   = q_idx.pop_front();
          e_res = q_res.pop_front();
          e_st  = q_st.pop_front();
          e_tag = q_tag.pop_front();
          if (out_result_i !== e_res || out_status_i !== e_st || out_tag_i !== e_tag) begin
            err_count_o++;
            $display("FAIL %0d ns: test %0d got %h/%b tag %0d, expected %h/%b tag %0d",
                     $time, idx, out_result_i, out_status_i, out_tag_i, e_res, e_st, e_tag);
          end else begin
            pass_count_o++;
            $display("PASS test %0d: result %h flags %b tag %0d", idx, e_res, e_st, e_tag);
          end
        end
      end
      if (in_valid_i && in_ready_i) begin
        last_idx = exp_idx_i;
        if (exp_valid_i) begin
          q_idx.push_back(exp_idx_i);
          q_res.push_back(exp_result_i);
          q_st.push_back(exp_status_i);
          q_tag.push_back(in_tag_i);
        end
      end
      flush_q    = flush_i;
      stall_q    = out_valid_i && !out_ready_i && !flush_i;
      stall_data = {out_result_i, out_status_i, out_tag_i};
    end
    pending_o = q_idx.size();
  end

endmodule

`default_nettype wire

// ==== dv/tb_divsqrt.sv ====
// testbench for the FP32 divide / square-root unit
// applies a table of operations under a random output stall,
// flushes one operation in flight, checks through divsqrt_monitor
`timescale 1ns/1ps
`default_nettype none

module tb_divsqrt;

  localparam int TAG_WIDTH = 4;
  localparam int N_MAX     = 16;
  localparam int TIMEOUT   = 200;  // cycles allowed per wait

  localparam divsqrt_pkg::op_e     DIV  = divsqrt_pkg::DIV;
  localparam divsqrt_pkg::op_e     SQRT = divsqrt_pkg::SQRT;
  localparam divsqrt_pkg::status_t NONE = 5'b00000;
  localparam divsqrt_pkg::status_t NV   = 5'b10000;
  localparam divsqrt_pkg::status_t DZ   = 5'b01000;
  localparam divsqrt_pkg::status_t OFNX = 5'b00101;
  localparam divsqrt_pkg::status_t UFNX = 5'b00011;
  localparam divsqrt_pkg::status_t NX   = 5'b00001;

  logic                  clk, rst, in_valid, in_ready, flush, out_valid, out_ready, busy;
  divsqrt_pkg::fp_word_t op_a, op_b, result;
  divsqrt_pkg::op_e      op;
  divsqrt_pkg::status_t  status;
  logic [TAG_WIDTH-1:0]  tag_in, tag_out;

  // expected values handed to the monitor with each operation
  logic                  exp_valid;
  int                    exp_idx, pass_count, err_count, pending;
  divsqrt_pkg::fp_word_t exp_result;
  divsqrt_pkg::status_t  exp_status;

  // --------------------
  // stimulus table, the tag of entry i is i
  divsqrt_pkg::op_e      t_op [N_MAX];
  divsqrt_pkg::fp_word_t t_a [N_MAX], t_b [N_MAX], t_res [N_MAX];
  divsqrt_pkg::status_t  t_st [N_MAX];
  logic                  t_flush [N_MAX];  // flushed in flight, no result expected
  int                    n_entries;
  integer                seed;
  logic                  timed_out;

  divsqrt_top #(.TAG_WIDTH(TAG_WIDTH)) UUT (
    .clk_i (clk), .rst_i (rst), .operand_a_i (op_a), .operand_b_i (op_b), .op_i (op),
    .tag_i (tag_in), .in_valid_i (in_valid), .in_ready_o (in_ready), .flush_i (flush),
    .result_o (result), .status_o (status), .tag_o (tag_out), .out_valid_o (out_valid),
    .out_ready_i (out_ready), .busy_o (busy)
  );

  divsqrt_monitor #(.TAG_WIDTH(TAG_WIDTH)) u_monitor (
    .clk_i (clk), .rst_i (rst), .in_valid_i (in_valid), .in_ready_i (in_ready),
    .in_tag_i (tag_in), .flush_i (flush), .out_valid_i (out_valid), .out_ready_i (out_ready),
    .out_result_i (result), .out_status_i (status), .out_tag_i (tag_out), .busy_i (busy),
    .exp_valid_i (exp_valid), .exp_idx_i (exp_idx), .exp_result_i (exp_result),
    .exp_status_i (exp_status), .pass_count_o (pass_count), .err_count_o (err_count),
    .pending_o (pending)
  );

  always #50 clk = ~clk;

  // random downstream stall, ready about 3 cycles in 4
  always @(negedge clk) begin
    out_ready = ($random(seed) & 3) != 0;
  end

  task automatic add_entry(input divsqrt_pkg::op_e o, input divsqrt_pkg::fp_word_t a, b, res,
                           input divsqrt_pkg::status_t st, input logic fl);
    t_op[n_entries]    = o;
    t_a[n_entries]     = a;
    t_b[n_entries]     = b;
    t_res[n_entries]   = res;
    t_st[n_entries]    = st;
    t_flush[n_entries] = fl;
    n_entries++;
  endtask

  task automatic load_table();
    add_entry(DIV,  32'h40C00000, 32'h40400000, 32'h40000000, NONE, 1'b0);  // 6/3
    add_entry(DIV,  32'hBFC00000, 32'h3F000000, 32'hC0400000, NONE, 1'b0);  // -1.5/0.5
    add_entry(DIV,  32'h3F800000, 32'h40400000, 32'h3EAAAAAA, NX,   1'b0);  // 1/3
    add_entry(SQRT, 32'h40000000, 32'h00000000, 32'h3FB504F3, NX,   1'b0);  // sqrt 2
    add_entry(SQRT, 32'h40800000, 32'h00000000, 32'h40000000, NONE, 1'b0);  // sqrt 4
    add_entry(DIV,  32'h3F800000, 32'h00000000, 32'h7F800000, DZ,   1'b0);  // 1/0
    add_entry(DIV,  32'h00000000, 32'h00000000, 32'h7FC00000, NV,   1'b0);  // 0/0
    add_entry(SQRT, 32'hC0800000, 32'h00000000, 32'h7FC00000, NV,   1'b0);  // sqrt -4
    add_entry(SQRT, 32'h7F800000, 32'h00000000, 32'h7F800000, NONE, 1'b0);  // sqrt +inf
    add_entry(DIV,  32'h7F800001, 32'h3F800000, 32'h7FC00000, NV,   1'b0);  // snan/1
    add_entry(DIV,  32'h7F7FFFFF, 32'h3F000000, 32'h7F7FFFFF, OFNX, 1'b0);  // max/0.5
    add_entry(DIV,  32'h00800000, 32'h40800000, 32'h00000000, UFNX, 1'b0);  // min/4
    add_entry(DIV,  32'h3F800000, 32'h40400000, 32'h3EAAAAAA, NX,   1'b1);  // flushed
    add_entry(DIV,  32'h40C00000, 32'h40400000, 32'h40000000, NONE, 1'b0);  // after flush
  endtask

  // called just after a falling edge, returns just after one
  task automatic send(input int i);
    int waits;
    op = t_op[i];
    op_a = t_a[i];
    op_b = t_b[i];
    tag_in = TAG_WIDTH'(i);
    in_valid = 1'b1;
    exp_valid = !t_flush[i];
    exp_idx = i;
    exp_result = t_res[i];
    exp_status = t_st[i];
    waits = 0;
    while (!in_ready && waits < TIMEOUT) begin  // taken at the next rising edge
      @(negedge clk);
      waits++;
    end
    if (!in_ready) begin
      $display("timeout: test %0d was never accepted by the DUT", i);
      timed_out = 1'b1;
    end
    @(negedge clk);
    in_valid = 1'b0;
    exp_valid = 1'b0;
  endtask

  task automatic wait_idle();
    int waits;
    waits = 0;
    while ((busy || pending != 0) && waits < TIMEOUT) begin
      @(negedge clk);
      waits++;
    end
    if (busy || pending != 0) begin
      $display("timeout: DUT did not drain within %0d cycles", TIMEOUT);
      timed_out = 1'b1;
    end
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    in_valid = 1'b0;
    flush = 1'b0;
    out_ready = 1'b1;
    op = DIV;
    op_a = '0;
    op_b = '0;
    tag_in = '0;
    exp_valid = 1'b0;
    exp_idx = 0;
    exp_result = '0;
    exp_status = '0;
    seed = 11;
    n_entries = 0;
    timed_out = 1'b0;
    load_table();
    repeat (16) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < n_entries && !timed_out; i++) begin
      if (t_flush[i]) wait_idle();  // only the flushed op in flight
      if (!timed_out) send(i);
      if (t_flush[i] && !timed_out) begin
        repeat (5) @(negedge clk);  // op is deep in the recurrence by now
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        @(negedge clk);
      end
    end
    if (!timed_out) wait_idle();
    $display("%0d tests passed, %0d errors, timeout %0d", pass_count, err_count, timed_out);
    if (err_count == 0 && !timed_out) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
hw/divsqrt_pkg.sv
hw/pipe_stage.sv
hw/divsqrt_special.sv
hw/divsqrt_iter.sv
hw/divsqrt_ctrl.sv
hw/divsqrt_top.sv
dv/divsqrt_monitor.sv
dv/tb_divsqrt.sv

// ==== Makefile ====
# Verilator build and run for the FP32 divide / square-root unit

SRCS := $(shell cat sources.f)

obj_dir/Vtb_divsqrt: sources.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_divsqrt -f sources.f -Mdir obj_dir

# the log decides, the simulator exit status is not used
run: obj_dir/Vtb_divsqrt
	./obj_dir/Vtb_divsqrt | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
